// ==== hw/fb_pkg.sv ====
/* framebuffer package
   720p raster positions, framebuffer geometry and the raster and video structs */
`default_nettype none

package fb_pkg;

    localparam int CORDW = 16;  // signed screen coordinates

    // blanking is 110 front porch then 40 sync then 220 back porch
    localparam logic signed [CORDW-1:0] H_STA  = -370;
    localparam logic signed [CORDW-1:0] HS_STA = -260;
    localparam logic signed [CORDW-1:0] HS_END = -220;
    localparam logic signed [CORDW-1:0] HA_STA = 0;
    localparam logic signed [CORDW-1:0] HA_END = 1279;  // last active pixel

    localparam logic signed [CORDW-1:0] V_STA  = -30;
    localparam logic signed [CORDW-1:0] VS_STA = -25;
    localparam logic signed [CORDW-1:0] VS_END = -20;
    localparam logic signed [CORDW-1:0] VA_STA = 0;
    localparam logic signed [CORDW-1:0] VA_END = 719;   // last active line

    localparam int H_TOTAL = 1650;
    localparam int V_TOTAL = 750;

    // 1-bit framebuffer shown top left
    localparam int FB_WIDTH  = 160;
    localparam int FB_HEIGHT = 120;
    localparam int FB_PIXELS = FB_WIDTH * FB_HEIGHT;
    localparam int FB_ADDRW  = $clog2(FB_PIXELS);
    localparam int FB_DATAW  = 1;  // colour bits per pixel

    typedef struct packed {
        logic signed [CORDW-1:0] sx;
        logic signed [CORDW-1:0] sy;
        logic                    hsync;
        logic                    vsync;
        logic                    de;
        logic                    frame;  // one cycle at raster origin
    } raster_t;

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
        logic       hsync;
        logic       vsync;
        logic       de;
    } video_t;

endpackage

`default_nettype wire

// ==== hw/display_timings.sv ====
/* display timings
   scans the 1650x750 raster for 720p and decodes sync, data enable and frame */
`default_nettype none
`timescale 1ns/1ns

module display_timings (
    input  wire logic       clk_pix,
    input  wire logic       rst_n,
    output fb_pkg::raster_t raster
);

    logic signed [fb_pkg::CORDW-1:0] sx_next;
    logic signed [fb_pkg::CORDW-1:0] sy_next;
    logic running;  // low on the first clock out of reset

    // next position, held at origin until running
    always_comb begin
        if (!running) begin
            sx_next = fb_pkg::H_STA;
            sy_next = fb_pkg::V_STA;
        end else if (raster.sx == fb_pkg::HA_END) begin
            sx_next = fb_pkg::H_STA;
            if (raster.sy == fb_pkg::VA_END) begin
                sy_next = fb_pkg::V_STA;
            end else begin
                sy_next = raster.sy + 1'b1;
            end
        end else begin
            sx_next = raster.sx + 1'b1;
            sy_next = raster.sy;
        end
    end

    // decodes come from the next position so every field lines up
    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            running      <= 1'b0;
            raster.sx    <= fb_pkg::H_STA;
            raster.sy    <= fb_pkg::V_STA;
            raster.hsync <= 1'b0;
            raster.vsync <= 1'b0;
            raster.de    <= 1'b0;
            raster.frame <= 1'b0;
        end else begin
            running      <= 1'b1;
            raster.sx    <= sx_next;
            raster.sy    <= sy_next;
            raster.hsync <= (sx_next >= fb_pkg::HS_STA) && (sx_next < fb_pkg::HS_END);
            raster.vsync <= (sy_next >= fb_pkg::VS_STA) && (sy_next < fb_pkg::VS_END);
            raster.de    <= (sx_next >= fb_pkg::HA_STA) && (sy_next >= fb_pkg::VA_STA);
            raster.frame <= (sx_next == fb_pkg::H_STA) && (sy_next == fb_pkg::V_STA);
        end
    end

    // frame follows the last active pixel, except straight out of reset
    frame_after_wrap: assert property (
        @(posedge clk_pix) disable iff (!rst_n)
        raster.frame && $past(running)
            |-> (($past(raster.sx) == fb_pkg::HA_END) && ($past(raster.sy) == fb_pkg::VA_END))
    );

endmodule

`default_nettype wire

// ==== hw/bram_sdp.sv ====
/* simple dual-port block RAM
   one write port, one registered read port, cleared to zero at start */
`default_nettype none
`timescale 1ns/1ns

module bram_sdp (
    input  wire logic                        clk_pix,
    input  wire logic                        we,
    input  wire logic [fb_pkg::FB_ADDRW-1:0] addr_write,
    input  wire logic [fb_pkg::FB_ADDRW-1:0] addr_read,
    input  wire logic [fb_pkg::FB_DATAW-1:0] data_in,
    output logic      [fb_pkg::FB_DATAW-1:0] data_out
);

    logic [fb_pkg::FB_DATAW-1:0] mem [fb_pkg::FB_PIXELS];

    // no image file, so the buffer starts black
    initial begin
        for (int i = 0; i < fb_pkg::FB_PIXELS; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk_pix) begin
        if (we) begin
            mem[addr_write] <= data_in;
        end
        data_out <= mem[addr_read];  // one cycle read latency
    end

    write_in_range: assert property (
        @(posedge clk_pix) we |-> addr_write < fb_pkg::FB_PIXELS
    );

endmodule

`default_nettype wire

// ==== hw/fb_border_draw.sv ====
/* border drawing engine
   writes a one-pixel white frame around the framebuffer once after reset */
`default_nettype none
`timescale 1ns/1ns

module fb_border_draw (
    input  wire logic                   clk_pix,
    input  wire logic                   rst_n,
    input  wire logic                   frame,
    output logic                        we,
    output logic [fb_pkg::FB_ADDRW-1:0] addr_write,
    output logic [fb_pkg::FB_DATAW-1:0] data_in
);

    typedef enum logic [2:0] {
        st_idle,
        st_top,
        st_right,
        st_left,
        st_bottom,
        st_done
    } state_t;

    state_t state;
    logic [$clog2(fb_pkg::FB_WIDTH)-1:0] cnt;  // pixels along the current edge

    assign data_in = '1;  // border is always white

    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            state <= st_idle;
            we    <= 1'b0;
            cnt   <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (frame) begin  // start in vertical blanking
                        we         <= 1'b1;
                        addr_write <= '0;
                        cnt        <= '0;
                        state      <= st_top;
                    end
                end
                st_top: begin
                    if (cnt < fb_pkg::FB_WIDTH - 1) begin
                        addr_write <= addr_write + 1'b1;
                        cnt        <= cnt + 1'b1;
                    end else begin
                        cnt   <= '0;
                        state <= st_right;  // continue down from the last column
                    end
                end
                st_right: begin
                    if (cnt < fb_pkg::FB_HEIGHT - 1) begin
                        addr_write <= addr_write + fb_pkg::FB_WIDTH[fb_pkg::FB_ADDRW-1:0];
                        cnt        <= cnt + 1'b1;
                    end else begin
                        addr_write <= '0;
                        cnt        <= '0;
                        state      <= st_left;
                    end
                end
                st_left: begin
                    if (cnt < fb_pkg::FB_HEIGHT - 1) begin
                        addr_write <= addr_write + fb_pkg::FB_WIDTH[fb_pkg::FB_ADDRW-1:0];
                        cnt        <= cnt + 1'b1;
                    end else begin
                        cnt   <= '0;
                        state <= st_bottom;  // already at start of last row
                    end
                end
                st_bottom: begin
                    if (cnt < fb_pkg::FB_WIDTH - 1) begin
                        addr_write <= addr_write + 1'b1;
                        cnt        <= cnt + 1'b1;
                    end else begin
                        we    <= 1'b0;
                        state <= st_done;
                    end
                end
                default: state <= st_done;  // stays here until reset
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/fb_scanout.sv ====
/* framebuffer scanout
   reads the buffer in step with the raster and drives colour and syncs */
`default_nettype none
`timescale 1ns/1ns

module fb_scanout (
    input  wire logic                        clk_pix,
    input  wire logic                        rst_n,
    input  wire fb_pkg::raster_t             raster,
    output logic      [fb_pkg::FB_ADDRW-1:0] addr_read,
    input  wire logic [fb_pkg::FB_DATAW-1:0] data_out,
    output fb_pkg::video_t                   video
);

    logic paint;     // raster inside the framebuffer window
    logic paint_p1;
    logic hsync_p1;
    logic vsync_p1;
    logic de_p1;
    logic colr_on;

    always_comb begin
        paint = (raster.sx >= 0) && (raster.sx < fb_pkg::FB_WIDTH)
             && (raster.sy >= 0) && (raster.sy < fb_pkg::FB_HEIGHT);
    end

    always_ff @(posedge clk_pix) begin
        if (!rst_n || raster.frame) begin
            addr_read <= '0;
        end else if (paint) begin
            if (addr_read == fb_pkg::FB_PIXELS - 1) begin
                addr_read <= '0;  // last pixel of the buffer
            end else begin
                addr_read <= addr_read + 1'b1;
            end
        end
    end

    // match the RAM read latency
    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            paint_p1 <= 1'b0;
            hsync_p1 <= 1'b0;
            vsync_p1 <= 1'b0;
            de_p1    <= 1'b0;
        end else begin
            paint_p1 <= paint;
            hsync_p1 <= raster.hsync;
            vsync_p1 <= raster.vsync;
            de_p1    <= raster.de;
        end
    end

    assign colr_on = paint_p1 && data_out[0];

    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            video <= '0;
        end else begin
            video.red   <= colr_on ? 8'hFF : 8'h00;
            video.green <= colr_on ? 8'hFF : 8'h00;
            video.blue  <= colr_on ? 8'hFF : 8'h00;
            video.hsync <= hsync_p1;
            video.vsync <= vsync_p1;
            video.de    <= de_p1;
        end
    end

    // read address tracks the window pixel, so it stays inside the buffer
    read_in_step: assert property (
        @(posedge clk_pix) disable iff (!rst_n)
        paint |-> addr_read == raster.sy * fb_pkg::FB_WIDTH + raster.sx
    );

endmodule

`default_nettype wire

// ==== hw/framebuffer_top.sv ====
/* framebuffer display top
   timing, border drawing, frame RAM and scanout for a 720p video stream */
`default_nettype none
`timescale 1ns/1ns

module framebuffer_top (
    input  wire logic      clk_pix,
    input  wire logic      rst_n,
    output fb_pkg::video_t video
);

    fb_pkg::raster_t raster;

    logic                        fb_we;
    logic [fb_pkg::FB_ADDRW-1:0] fb_addr_write;
    logic [fb_pkg::FB_ADDRW-1:0] fb_addr_read;
    logic [fb_pkg::FB_DATAW-1:0] fb_data_in;
    logic [fb_pkg::FB_DATAW-1:0] fb_data_out;

    display_timings timings_inst (
        .clk_pix (clk_pix),
        .rst_n   (rst_n),
        .raster  (raster)
    );

    fb_border_draw draw_inst (
        .clk_pix    (clk_pix),
        .rst_n      (rst_n),
        .frame      (raster.frame),  // drawing starts on first frame
        .we         (fb_we),
        .addr_write (fb_addr_write),
        .data_in    (fb_data_in)
    );

    bram_sdp bram_inst (
        .clk_pix    (clk_pix),
        .we         (fb_we),
        .addr_write (fb_addr_write),
        .addr_read  (fb_addr_read),
        .data_in    (fb_data_in),
        .data_out   (fb_data_out)
    );

    fb_scanout scanout_inst (
        .clk_pix   (clk_pix),
        .rst_n     (rst_n),
        .raster    (raster),
        .addr_read (fb_addr_read),
        .data_out  (fb_data_out),
        .video     (video)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_framebuffer_top.sv ====
/* testbench for the framebuffer display top
   checks reset, raster timing and the border image against a reference raster */
`default_nettype none
`timescale 1ns/1ns

module tb_framebuffer_top;

    localparam int FRAME_CYCLES = fb_pkg::H_TOTAL * fb_pkg::V_TOTAL;
    localparam int WIN_LINES    = fb_pkg::VA_STA - fb_pkg::V_STA + fb_pkg::FB_HEIGHT;
    localparam int WIN_CYCLES   = WIN_LINES * fb_pkg::H_TOTAL;  // blanking plus window rows
    localparam int BORDER_PIX   = 2 * fb_pkg::FB_WIDTH + 2 * (fb_pkg::FB_HEIGHT - 2);
    localparam int LINE_HS      = fb_pkg::HS_END - fb_pkg::HS_STA;
    localparam int LINE_DE      = fb_pkg::HA_END - fb_pkg::HA_STA + 1;
    localparam int VS_LINES     = fb_pkg::VS_END - fb_pkg::VS_STA;
    localparam int ACT_LINES    = fb_pkg::VA_END - fb_pkg::VA_STA + 1;
    // three full frames and one window plus margin
    localparam int TIMEOUT_CYCLES = 3 * FRAME_CYCLES + WIN_CYCLES + 40_000;
    localparam int MAX_SHOWN      = 20;

    logic           clk_pix;
    logic           rst_n;
    fb_pkg::video_t video;

    int   cycles;
    int   checks;
    int   errors;
    int   tests;
    int   pix;        // reference index of the pixel now on the output
    int   scan_cyc;
    int   last_rise;  // cycle of the previous hsync rise
    logic hs_prev;
    int   line_hs;
    int   line_de;
    int   line_vs;
    int   vs_lines;
    int   active_lines;
    int   white_win;
    int   lit_out;

    framebuffer_top DUT (
        .clk_pix (clk_pix),
        .rst_n   (rst_n),
        .video   (video)
    );

    initial begin
        clk_pix = 1'b0;
        forever #4 clk_pix = ~clk_pix;
    end

    initial begin : watchdog
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk_pix);
            cycles++;
        end
        $display("timeout: tests still running after %0d clock cycles", cycles);
        $display("TESTBENCH FAILED");
        $finish;
    end

    function automatic int pos_x(int idx);
        return fb_pkg::H_STA + idx % fb_pkg::H_TOTAL;
    endfunction

    function automatic int pos_y(int idx);
        return fb_pkg::V_STA + (idx / fb_pkg::H_TOTAL) % fb_pkg::V_TOTAL;
    endfunction

    function automatic logic in_window(int x, int y);
        return x >= 0 && x < fb_pkg::FB_WIDTH && y >= 0 && y < fb_pkg::FB_HEIGHT;
    endfunction

    // timing decodes and the one-pixel border rule
    function automatic fb_pkg::video_t expect_video(int idx);
        fb_pkg::video_t v;
        int   x;
        int   y;
        logic lit;
        x = pos_x(idx);
        y = pos_y(idx);
        lit = in_window(x, y) && (x == 0 || y == 0 || x == fb_pkg::FB_WIDTH - 1
              || y == fb_pkg::FB_HEIGHT - 1);
        v.red   = lit ? 8'hff : 8'h00;
        v.green = v.red;
        v.blue  = v.red;
        v.hsync = x >= fb_pkg::HS_STA && x < fb_pkg::HS_END;
        v.vsync = y >= fb_pkg::VS_STA && y < fb_pkg::VS_END;
        v.de    = x >= 0 && y >= 0;
        return v;
    endfunction

    task automatic log_error(string msg);
        errors++;
        if (errors <= MAX_SHOWN) begin
            $display("error: %0t ns: %s", $time, msg);
        end else if (errors == MAX_SHOWN + 1) begin
            $display("too many mismatches, later error lines are not shown");
        end
    endtask

    task automatic check_video(fb_pkg::video_t got, fb_pkg::video_t exp, string what);
        checks++;
        if (got !== exp) begin
            log_error($sformatf("%s: video %h, expected %h", what, got, exp));
        end
    endtask

    task automatic check_count(int got, int exp, string what);
        checks++;
        if (got != exp) begin
            log_error($sformatf("%s: got %0d, expected %0d", what, got, exp));
        end
    endtask

    // rst_n low for 8 cycles, then wait for the raster origin at the output
    task automatic apply_reset();
        fb_pkg::video_t blank;
        blank = '0;
        @(posedge clk_pix);
        rst_n <= 1'b0;
        for (int i = 1; i <= 8; i++) begin
            @(posedge clk_pix);
            if (i == 8) begin
                rst_n <= 1'b1;
            end
            @(negedge clk_pix);
            check_video(video, blank, "in reset");
        end
        repeat (2) begin  // pipeline still flushing
            @(negedge clk_pix);
            check_video(video, blank, "first output cycles");
        end
        pix       = 0;
        last_rise = -1;
        hs_prev   = 1'b0;
    endtask

    // compare n output cycles against the reference and gather line counts
    task automatic scan_video(int n, string what);
        fb_pkg::video_t exp;
        int x;
        int y;
        repeat (n) begin
            @(negedge clk_pix);
            x   = pos_x(pix);
            y   = pos_y(pix);
            exp = expect_video(pix);
            check_video(video, exp, what);
            if (x == fb_pkg::H_STA) begin
                line_hs = 0;
                line_de = 0;
                line_vs = 0;
            end
            line_hs += int'(video.hsync);
            line_de += int'(video.de);
            line_vs += int'(video.vsync);
            if (video.hsync && !hs_prev) begin
                if (last_rise >= 0) begin
                    check_count(scan_cyc - last_rise, fb_pkg::H_TOTAL, "line period");
                end
                last_rise = scan_cyc;
            end
            hs_prev = video.hsync;
            if (in_window(x, y) && video.red == 8'hff) begin
                white_win++;
            end else if (!in_window(x, y) && {video.red, video.green, video.blue} != '0) begin
                lit_out++;
            end
            if (x == fb_pkg::HA_END) begin  // last pixel of the line
                check_count(line_hs, LINE_HS, "hsync cycles in line");
                if (line_de != 0) begin
                    check_count(line_de, LINE_DE, "de cycles in line");
                    active_lines++;
                end
                if (line_vs != 0) begin
                    vs_lines++;
                end
            end
            pix = (pix + 1) % FRAME_CYCLES;
            scan_cyc++;
        end
    endtask

    task automatic finish_test(string name, int errs_before);
        tests++;
        if (errors == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - errs_before);
        end
    endtask

    task automatic test_reset_state();
        int e0;
        e0 = errors;
        apply_reset();
        finish_test("reset state", e0);
    endtask

    task automatic test_line_frame_timing();
        int e0;
        e0 = errors;
        vs_lines     = 0;
        active_lines = 0;
        scan_video(FRAME_CYCLES, "frame 1");
        check_count(vs_lines, VS_LINES, "vsync lines in frame");
        check_count(active_lines, ACT_LINES, "active lines in frame");
        finish_test("line and frame timing", e0);
    endtask

    task automatic test_border_image();
        int e0;
        e0 = errors;
        white_win = 0;
        scan_video(WIN_CYCLES, "frame 2 window rows");
        check_count(white_win, BORDER_PIX, "white pixels in window");
        finish_test("border image", e0);
    endtask

    task automatic test_outside_window();
        int e0;
        e0 = errors;
        lit_out = 0;
        scan_video(FRAME_CYCLES - WIN_CYCLES, "frame 2 below window");
        check_count(lit_out, 0, "lit pixels outside window");
        finish_test("outside the window", e0);
    endtask

    task automatic test_steady_image();
        int e0;
        e0 = errors;
        white_win = 0;
        scan_video(WIN_CYCLES, "frame 3 window rows");
        check_count(white_win, BORDER_PIX, "white pixels in frame 3 window");
        finish_test("steady image", e0);
    endtask

    // raster sits just below the window here, well inside the frame
    task automatic test_midframe_reset();
        int e0;
        e0 = errors;
        apply_reset();
        white_win = 0;
        lit_out   = 0;
        scan_video(FRAME_CYCLES, "frame after reset");
        check_count(white_win, BORDER_PIX, "white pixels after reset");
        check_count(lit_out, 0, "lit pixels outside window after reset");
        finish_test("mid-frame reset", e0);
    endtask

    initial begin
        rst_n        = 1'b0;
        checks       = 0;
        errors       = 0;
        tests        = 0;
        pix          = 0;
        scan_cyc     = 0;
        last_rise    = -1;
        hs_prev      = 1'b0;
        line_hs      = 0;
        line_de      = 0;
        line_vs      = 0;
        vs_lines     = 0;
        active_lines = 0;
        white_win    = 0;
        lit_out      = 0;

        test_reset_state();
        test_line_frame_timing();
        test_border_image();
        test_outside_window();
        test_steady_image();
        test_midframe_reset();

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== framebuffer_david.f ====
hw/fb_pkg.sv
hw/display_timings.sv
hw/bram_sdp.sv
hw/fb_border_draw.sv
hw/fb_scanout.sv
hw/framebuffer_top.sv
testbench/tb_framebuffer_top.sv

// ==== Makefile ====
# Verilator build for the framebuffer display subsystem

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
LINTFLAGS ?= --lint-only --timing
TOP       ?= tb_framebuffer_top
FILELIST  ?= framebuffer_david.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := TESTBENCH PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
